// File: src.f
+incdir+include
rtl/fc_pkg.sv
rtl/fc_beat_fifo.sv
rtl/fc_mac_pe.sv
rtl/fc_output_stage.sv
rtl/fc_core.sv
dv/fc_tb.sv

// File: dv/fc_tb.sv
/*
 * Fully connected core testbench
 * Credit-driven source and sink around the core, a reference model of
 * the lane math, requantization and argmax, and an in-order result checker
 */
`include "fc_params.svh"

module fc_tb;
  import fc_pkg::*;

  localparam int LANES      = `FC_LANES;
  localparam int MAX_BEATS  = 8;
  localparam int WAIT_LIMIT = 1000;

  logic       clk;
  logic       rstn;
  logic       in_valid;
  fc_beat_t   in_beat;
  logic       in_credit;
  logic       out_valid;
  fc_result_t out_result;
  logic       out_credit;

  fc_beat_t   vec [MAX_BEATS];
  int         vec_len;
  fc_result_t exp_q [$];
  int         seed = 14;
  int         beats_sent = 0;
  int         credit_returns = 0;
  int         peak_outstanding = 0;
  int         results_seen = 0;
  int         owed = 0;
  logic       sink_open;
  int         value_errors = 0;
  int         order_errors = 0;
  int         credit_errors = 0;
  int         flow_errors = 0;

  fc_core u_dut (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic fc_result_t fc_ref(input fc_beat_t beats [MAX_BEATS], input int n);
    fc_result_t r;
    data_t      f;
    data_t      w;
    data_t      b;
    int         acc;
    int         best;
    r    = '0;
    best = -1;
    for (int l = 0; l < LANES; l++) begin
      b   = beats[0].bias[l];
      acc = int'(b);
      for (int k = 0; k < n; k++) begin
        f   = beats[k].feat;
        w   = beats[k].weights[l];
        acc = acc + int'(f) * int'(w);
      end
      // ReLU, saturation, then drop the fraction bits
      if (acc < 0) begin
        r.q[l] = 8'd0;
      end else if (acc >= (1 << `FC_SAT_BIT)) begin
        r.q[l] = 8'd127;
      end else begin
        r.q[l] = 8'(acc >> `FC_FRAC_SHIFT);
      end
      if (int'(r.q[l]) > best) begin
        best      = int'(r.q[l]);
        r.max_idx = lane_idx_t'(l);
      end
    end
    return r;
  endfunction

  task automatic report_counts();
    $display("Errors: %0d value, %0d ordering, %0d credit, %0d flow",
             value_errors, order_errors, credit_errors, flow_errors);
  endtask

  task automatic abort_run(input string why);
    $display("Timeout while waiting: %s", why);
    report_counts();
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Stimulus
  task automatic set_beat(input int k, input int n, input data_t feat,
                          input logic [LANES*8-1:0] w, input logic [LANES*8-1:0] b);
    vec[k].feat = feat;
    for (int l = 0; l < LANES; l++) begin
      vec[k].weights[l] = w[8*l +: 8];
      vec[k].bias[l]    = b[8*l +: 8];
    end
    vec[k].first = (k == 0);
    vec[k].last  = (k == n - 1);
    vec_len      = n;
  endtask

  task automatic build_random_vector(input int max_len);
    int n;
    n = 1 + int'($unsigned($random(seed)) % max_len);
    for (int k = 0; k < n; k++) begin
      set_beat(k, n, data_t'($random(seed)), $random(seed), $random(seed));
    end
  endtask

  task automatic drive_beat(input fc_beat_t b);
    int waited;
    waited = 0;
    @(posedge clk);
    while (beats_sent - credit_returns >= `FC_IN_DEPTH) begin
      in_valid <= 1'b0;
      if (waited == WAIT_LIMIT) begin
        abort_run("source held no input credit");
      end
      waited++;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_beat  <= b;
    beats_sent++;
    if (beats_sent - credit_returns > peak_outstanding) begin
      peak_outstanding = beats_sent - credit_returns;
    end
  endtask

  task automatic send_vector();
    exp_q.push_back(fc_ref(vec, vec_len));
    for (int k = 0; k < vec_len; k++) begin
      drive_beat(vec[k]);
    end
  endtask

  task automatic send_one(input data_t feat, input logic [LANES*8-1:0] w);
    set_beat(0, 1, feat, w, '0);
    send_vector();
  endtask

  task automatic idle_input();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_results(input int target, input string what);
    int waited;
    waited = 0;
    while (results_seen < target) begin
      if (waited == WAIT_LIMIT) begin
        abort_run(what);
      end
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == WAIT_LIMIT) begin
        abort_run(what);
      end
      waited++;
      @(posedge clk);
    end
    // Sink hands back its last credits
    repeat (4) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sink, credit monitor and result checker
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : sink_model
    int held;
    held = owed + (out_valid ? 1 : 0);
    if (!rstn) begin
      out_credit <= 1'b0;
      owed       <= 0;
    end else if (sink_open && held > 0) begin
      out_credit <= 1'b1;
      owed       <= held - 1;
    end else begin
      out_credit <= 1'b0;
      owed       <= held;
    end
  end

  always @(posedge clk) begin
    if (rstn && in_credit) begin
      credit_returns <= credit_returns + 1;
      assert (credit_returns < beats_sent) else begin
        credit_errors++;
        $display("Input credit returned for a beat that was never sent");
      end
    end
  end

  always @(posedge clk) begin : result_check
    fc_result_t exp_r;
    if (rstn && out_valid) begin
      results_seen <= results_seen + 1;
      assert (exp_q.size() != 0) else begin
        order_errors++;
        $display("Result appeared with no vector outstanding");
      end
      if (exp_q.size() != 0) begin
        exp_r = exp_q.pop_front();
        assert (out_result.q == exp_r.q) else begin
          value_errors++;
          $display("[ERROR] out_result.q expected %h got %h", exp_r.q, out_result.q);
        end
        assert (out_result.max_idx == exp_r.max_idx) else begin
          value_errors++;
          $display("[ERROR] out_result.max_idx expected %h got %h",
                   exp_r.max_idx, out_result.max_idx);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin : main_seq
    int               base;
    logic [LANES*8-1:0] w;
    rstn       = 1'b0;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_credit = 1'b0;
    sink_open  = 1'b1;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    assert (!out_valid) else begin
      flow_errors++;
      $display("[ERROR] out_valid after reset expected 0 got %h", out_valid);
    end
    assert (!in_credit) else begin
      flow_errors++;
      $display("[ERROR] in_credit after reset expected 0 got %h", in_credit);
    end

    // Random vectors back to back
    repeat (20) begin
      build_random_vector(MAX_BEATS);
      send_vector();
    end
    idle_input();
    wait_drain("random vector results");

    // Negative, saturating, shifted and 0x80 lanes
    set_beat(0, 2, 8'h80, 32'hCEFF_8064, 32'h8040_0005);
    set_beat(1, 2, 8'h28, 32'h8014_7FFD, 32'h0000_0000);
    send_vector();
    send_one(8'h80, 32'h8080_8080);

    // Maximum in each lane, then ties; a feature of 64 makes q equal the weight
    for (int p = 0; p < LANES; p++) begin
      w             = {LANES{8'h0A}};
      w[8*p +: 8]   = 8'h5A;
      send_one(8'h40, w);
    end
    send_one(8'h40, 32'h3232_3232);
    send_one(8'h40, 32'h1446_4614);
    send_one(8'h40, 32'h4646_1414);
    send_one(8'h40, 32'hFBFB_FBFB);
    send_one(8'h40, 32'h7F7E_7F7E);
    idle_input();
    wait_drain("directed vector results");

    // Sink withholds output credits
    @(posedge clk);
    sink_open <= 1'b0;
    base = results_seen;
    repeat (4) begin
      build_random_vector(2);
      send_vector();
    end
    idle_input();
    wait_results(base + `FC_OUT_CREDITS, "results covered by initial credits");
    for (int c = 0; c < 30; c++) begin
      @(posedge clk);
      assert (!out_valid) else begin
        flow_errors++;
        $display("[ERROR] out_valid without output credit expected 0 got %h", out_valid);
      end
    end
    assert (results_seen == base + `FC_OUT_CREDITS) else begin
      flow_errors++;
      $display("[ERROR] results_seen while credits withheld expected %h got %h",
               base + `FC_OUT_CREDITS, results_seen);
    end
    sink_open <= 1'b1;
    wait_results(base + 4, "results after credits came back");
    wait_drain("withheld results");

    // Credit accounting once traffic has drained
    assert (credit_returns == beats_sent) else begin
      flow_errors++;
      $display("[ERROR] in_credit pulses expected %h got %h", beats_sent, credit_returns);
    end
    // Streaming fills the whole credit window only if credits come back on pop
    assert (peak_outstanding == `FC_IN_DEPTH) else begin
      flow_errors++;
      $display("[ERROR] peak_outstanding expected %h got %h",
               `FC_IN_DEPTH, peak_outstanding);
    end

    report_counts();
    if (value_errors + order_errors + credit_errors + flow_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/fc_core.sv
/*
 * Fully connected compute core
 * Input beat buffer feeding four MAC lanes in parallel, with the
 * output stage producing requantized bytes and the argmax index
 */
`include "fc_params.svh"

module fc_core (
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_valid,
  input  fc_pkg::fc_beat_t   in_beat,
  output logic               in_credit,
  output logic               out_valid,
  output fc_pkg::fc_result_t out_result,
  input  logic               out_credit
);
  import fc_pkg::*;

  fc_beat_t                      head;
  logic                          advance;
  logic                          pe_valid;
  fc_lane_out_t [`FC_LANES-1:0]  lane_outs;
  logic [`FC_LANES-1:0]          lane_valid;

  fc_beat_fifo u_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .advance   (advance),
    .pe_valid  (pe_valid),
    .head      (head),
    .in_credit (in_credit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // MAC lanes, one feature byte shared by all
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < `FC_LANES; i++) begin : g_lane
    fc_mac_pe u_pe (
      .clk        (clk),
      .rstn       (rstn),
      .advance    (advance),
      .pe_valid   (pe_valid),
      .feat       (head.feat),
      .weight     (head.weights[i]),
      .bias       (head.bias[i]),
      .first      (head.first),
      .last       (head.last),
      .lane_out   (lane_outs[i]),
      .lane_valid (lane_valid[i])
    );
  end

  fc_output_stage u_out (
    .clk        (clk),
    .rstn       (rstn),
    .lane_valid (lane_valid[0]),
    .lane_outs  (lane_outs),
    .advance    (advance),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

endmodule

// File: rtl/fc_output_stage.sv
/*
 * Output stage
 * ReLU and saturating requantization of each lane to 7 bits, argmax
 * with the lowest index winning ties, result register and output credits
 */
`include "fc_params.svh"

module fc_output_stage (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  lane_valid,
  input  fc_pkg::fc_lane_out_t [`FC_LANES-1:0]  lane_outs,
  output logic                                  advance,
  output logic                                  out_valid,
  output fc_pkg::fc_result_t                    out_result,
  input  logic                                  out_credit
);
  import fc_pkg::*;

  localparam int LANES  = `FC_LANES;
  localparam int Q_W    = `FC_DATA_W - 1;
  localparam int CRED_W = $clog2(`FC_OUT_CREDITS + 1);

  qdata_t [LANES-1:0] q_next;
  qdata_t             best_q;
  lane_idx_t          idx_next;
  logic               load;
  logic               issue;
  logic               pending;
  logic [CRED_W-1:0]  credits;

  // ReLU, then clip to 127 or drop the fraction bits
  function automatic qdata_t requant(acc_t acc);
    qdata_t q;
    if (acc[`FC_ACC_W-1]) begin
      q = '0;
    end else if (|acc[`FC_ACC_W-2:`FC_SAT_BIT]) begin
      q = {1'b0, {Q_W{1'b1}}};
    end else begin
      q = {1'b0, acc[`FC_FRAC_SHIFT +: Q_W]};
    end
    return q;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Requantization and argmax
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      q_next[i] = requant(lane_outs[i].acc);
    end
    best_q   = q_next[0];
    idx_next = '0;
    // Strict compare keeps the earlier lane on a tie
    for (int i = 1; i < LANES; i++) begin
      if (q_next[i] > best_q) begin
        best_q   = q_next[i];
        idx_next = lane_idx_t'(i);
      end
    end
  end

  // Lanes run in lockstep, lane 0 stands for all of them
  assign load    = advance && lane_valid && lane_outs[0].last;
  assign issue   = (load || pending) && (credits != '0);
  assign advance = !pending;

  always_ff @(posedge clk) begin
    if (load) begin
      out_result.q       <= q_next;
      out_result.max_idx <= idx_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output handshake and credit counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
      pending   <= 1'b0;
      credits   <= CRED_W'(`FC_OUT_CREDITS);
    end else begin
      out_valid <= issue;
      // Held result waits here and freezes the pipeline
      pending   <= (load || pending) && !issue;
      credits   <= credits + CRED_W'(out_credit) - CRED_W'(issue);
    end
  end

endmodule

// File: rtl/fc_mac_pe.sv
/*
 * Multiply-accumulate lane
 * Three stage sign-magnitude multiplier built from partial products,
 * followed by an accumulator that restarts from the bias on first
 */
`include "fc_params.svh"

module fc_mac_pe (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 advance,
  input  logic                 pe_valid,
  input  fc_pkg::data_t        feat,
  input  fc_pkg::data_t        weight,
  input  fc_pkg::data_t        bias,
  input  logic                 first,
  input  logic                 last,
  output fc_pkg::fc_lane_out_t lane_out,
  output logic                 lane_valid
);
  import fc_pkg::*;

  localparam int MAG_W  = `FC_DATA_W;
  localparam int HALF   = MAG_W / 2;
  localparam int PSUM_W = MAG_W + HALF;
  localparam int PROD_W = 2 * MAG_W;

  logic [MAG_W-1:0]  a_mag;
  logic [MAG_W-1:0]  b_mag;
  logic [PSUM_W-1:0] psum_lo;
  logic [PSUM_W-1:0] psum_hi;
  logic [PROD_W-1:0] prod_mag;
  acc_t              prod_ext;

  // Stage registers
  logic              s1_valid, s1_first, s1_last, s1_sign;
  logic [MAG_W-1:0]  s1_a_mag, s1_b_mag;
  data_t             s1_bias;
  logic              s2_valid, s2_first, s2_last, s2_sign;
  logic [PSUM_W-1:0] s2_lo, s2_hi;
  data_t             s2_bias;
  logic              s3_valid, s3_first, s3_last;
  acc_t              s3_prod;
  data_t             s3_bias;
  logic              s4_valid, s4_last;
  acc_t              acc;

  // Magnitudes; 0x80 maps to 128, which still fits unsigned
  assign a_mag = feat[MAG_W-1] ? (~feat + 1'b1) : feat;
  assign b_mag = weight[MAG_W-1] ? (~weight + 1'b1) : weight;

  ////////////////////////////////////////////////////////////////////////////
  // Partial product rows, low and high halves of the multiplier
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    psum_lo = '0;
    psum_hi = '0;
    for (int i = 0; i < HALF; i++) begin
      if (s1_b_mag[i]) begin
        psum_lo = psum_lo + (PSUM_W'(s1_a_mag) << i);
      end
      if (s1_b_mag[i+HALF]) begin
        psum_hi = psum_hi + (PSUM_W'(s1_a_mag) << i);
      end
    end
  end

  assign prod_mag = PROD_W'(s2_lo) + (PROD_W'(s2_hi) << HALF);
  assign prod_ext = acc_t'(prod_mag);

  // Datapath, moves only on advance
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_a_mag <= a_mag;
      s1_b_mag <= b_mag;
      s1_sign  <= feat[MAG_W-1] ^ weight[MAG_W-1];
      s1_bias  <= bias;
      s1_first <= first;
      s1_last  <= last;

      s2_lo    <= psum_lo;
      s2_hi    <= psum_hi;
      s2_sign  <= s1_sign;
      s2_bias  <= s1_bias;
      s2_first <= s1_first;
      s2_last  <= s1_last;

      s3_prod  <= s2_sign ? -prod_ext : prod_ext;
      s3_bias  <= s2_bias;
      s3_first <= s2_first;
      s3_last  <= s2_last;

      // Bubbles leave the accumulator alone
      if (s3_valid) begin
        acc     <= s3_first ? (acc_t'(s3_bias) + s3_prod) : (acc + s3_prod);
        s4_last <= s3_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
      s4_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= pe_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      s4_valid <= s3_valid;
    end
  end

  assign lane_out.acc  = acc;
  assign lane_out.last = s4_last;
  assign lane_valid    = s4_valid;

endmodule

// File: rtl/fc_beat_fifo.sv
/*
 * Input beat buffer
 * Circular buffer of incoming beats; the head feeds the lanes and
 * each pop hands one credit back to the source a cycle later
 */
`include "fc_params.svh"

module fc_beat_fifo (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  input  fc_pkg::fc_beat_t in_beat,
  input  logic             advance,
  output logic             pe_valid,
  output fc_pkg::fc_beat_t head,
  output logic             in_credit
);
  import fc_pkg::*;

  localparam int DEPTH = `FC_IN_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fc_beat_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign pop      = advance && !empty;
  assign pe_valid = pop;
  assign head     = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, occupancy and credit return
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      // The source holds a credit for every write, so a slot is always free
      if (in_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
      in_credit <= pop;
    end
  end

endmodule

// File: rtl/fc_pkg.sv
/*
 * Fully connected core types
 * Operand, accumulator and result words, plus the beat, lane
 * output and result bundles passed between the blocks
 */
`include "fc_params.svh"

package fc_pkg;

  typedef logic signed [`FC_DATA_W-1:0] data_t;
  typedef logic signed [`FC_ACC_W-1:0]  acc_t;
  typedef logic [`FC_DATA_W-1:0]        qdata_t;
  typedef logic [$clog2(`FC_LANES)-1:0] lane_idx_t;

  // One input beat, a feature byte shared by all lanes
  typedef struct packed {
    data_t                   feat;
    data_t [`FC_LANES-1:0]   weights;
    data_t [`FC_LANES-1:0]   bias;     // only taken on first
    logic                    first;
    logic                    last;
  } fc_beat_t;

  typedef struct packed {
    acc_t acc;
    logic last;
  } fc_lane_out_t;

  typedef struct packed {
    qdata_t [`FC_LANES-1:0] q;
    lane_idx_t              max_idx;
  } fc_result_t;

endpackage

// File: include/fc_params.svh
/*
 * Fully connected core parameters
 * Lane count, operand and accumulator widths, requantization
 * shift and saturation point, buffer depth and output credits
 */
`ifndef FC_PARAMS_SVH
`define FC_PARAMS_SVH

// Output neurons computed in parallel
`define FC_LANES        4

// Operand and accumulator widths
`define FC_DATA_W       8
`define FC_ACC_W        28

// Requantization to 7 bits
`define FC_FRAC_SHIFT   6
`define FC_SAT_BIT      13

// Flow control
`define FC_IN_DEPTH     4
`define FC_OUT_CREDITS  2

`endif
